/* atc_tower.f */
+incdir+rtl
rtl/atc_msg_pkg.sv
rtl/atc_ctrl_pkg.sv
rtl/atc_fifo.sv
rtl/atc_id_pool.sv
rtl/atc_runway_lock.sv
rtl/atc_request_ctrl.sv
rtl/atc_reply_sender.sv
rtl/atc_tower.sv
tests/atc_tower_tb.sv

/* Bender.yml */
package:
  name: atc_tower

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/atc_msg_pkg.sv
      - rtl/atc_ctrl_pkg.sv
      - rtl/atc_fifo.sv
      - rtl/atc_id_pool.sv
      - rtl/atc_runway_lock.sv
      - rtl/atc_request_ctrl.sv
      - rtl/atc_reply_sender.sv
      - rtl/atc_tower.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/atc_tower_tb.sv

/* tests/atc_tower_tb.sv */
//////////////////////////////////////////////////
// Random message testbench for the tower controller
// Messages go one at a time and all of their replies
// are collected before the next one is sent
//////////////////////////////////////////////////

`default_nettype none

`include "atc_config.svh"

module atc_tower_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED = 32'ha2af_0b38;
  localparam int NUM_MESSAGES = 600;
  localparam int REPLY_TIMEOUT = 3000;
  localparam int QUIET_CYCLES = 12;

  logic clock;
  logic reset;
  atc_msg_pkg::msg_byte_t rx_data;
  logic rx_valid;
  logic tx_ready;
  atc_msg_pkg::msg_byte_t tx_data;
  logic tx_send;
  logic [1:0] runway_active;

  // Reference model state
  logic [`ATC_NUM_IDS-1:0] taken_map;
  logic [`ATC_ID_WIDTH-1:0] takeoff_q[$];
  logic [`ATC_ID_WIDTH-1:0] landing_q[$];
  logic [`ATC_ID_WIDTH-1:0] owner [2];
  logic [1:0] active;
  logic takeoff_turn;

  atc_msg_pkg::msg_byte_t expected[$];
  atc_msg_pkg::msg_byte_t received[$];
  logic ready_at_edge;
  int value_errors;
  int other_errors;
  int timeouts;

  atc_tower i_dut (
    .clock(clock), .reset(reset), .rx_data(rx_data), .rx_valid(rx_valid),
    .tx_ready(tx_ready), .tx_data(tx_data), .tx_send(tx_send),
    .runway_active(runway_active)
  );

  always #10 clock = ~clock;

  // tx_ready as the sender saw it at the rising edge
  always @(posedge clock) ready_at_edge = tx_ready;

  // Transmitted bytes are sampled mid-cycle
  always @(negedge clock) begin
    if (tx_send === 1'b1) begin
      assert (ready_at_edge === 1'b1) else begin
        other_errors++;
        $display("A byte was sent although tx_ready was low when the sender started it");
      end
      received.push_back(tx_data);
    end
  end

  function automatic atc_msg_pkg::msg_byte_t build_byte(
    logic [`ATC_ID_WIDTH-1:0] id, atc_msg_pkg::msg_type_t kind, logic action);
    return {id, kind, action};
  endfunction

  // Random stretches of tx_ready with some long low ones
  task automatic drive_ready();
    int len;
    logic level;
    forever begin
      if ($urandom_range(9) < 2) begin
        level = 1'b0;
        len = $urandom_range(80, 20);
      end else begin
        level = ($urandom_range(3) != 0);
        len = $urandom_range(8, 1);
      end
      repeat (len) begin
        @(negedge clock);
        tx_ready = level;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////

  // Few declares early on so that the pool and the queues fill up
  function automatic atc_msg_pkg::msg_byte_t choose_message(int index);
    int roll;
    int declare_weight;
    logic [`ATC_ID_WIDTH-1:0] id;
    logic [2:0] kind;
    logic action;
    declare_weight = (index < 150) ? 5 : 25;
    roll = $urandom_range(99);
    id = `ATC_ID_WIDTH'($urandom_range(`ATC_NUM_IDS - 1));
    action = 1'($urandom_range(1));
    if (roll < 30) begin
      kind = 3'd3;
    end else if (roll < 30 + declare_weight) begin
      kind = 3'd1;
      // Mostly the real owner and sometimes a stranger
      if (active[action] && $urandom_range(9) < 7) id = owner[action];
    end else if (roll < 90) begin
      kind = 3'd0;
      if (taken_map != '0 && $urandom_range(9) < 8) begin
        while (!taken_map[id]) id = id + 1'b1;
      end
    end else begin
      // Retired code 2 or one of the reply codes 4 to 7
      kind = 3'($urandom_range(4));
      kind = (kind == 3'd0) ? 3'd2 : kind + 3'd3;
    end
    return {id, kind, action};
  endfunction

  task automatic apply_message(input atc_msg_pkg::msg_byte_t m);
    logic [`ATC_ID_WIDTH-1:0] id;
    logic [2:0] kind;
    logic action;
    logic [`ATC_ID_WIDTH-1:0] plane;
    logic rw;
    logic from_takeoff;
    int lowest;
    int i;
    id = m[7:4];
    kind = m[3:1];
    action = m[0];
    case (kind)
      3'd0: begin
        if (taken_map[id]) begin
          if (action ? landing_q.size() == `ATC_LANDING_DEPTH
                     : takeoff_q.size() == `ATC_TAKEOFF_DEPTH) begin
            expected.push_back(build_byte(id, atc_msg_pkg::DIVERT, 1'b0));
            taken_map[id] = 1'b0;
          end else begin
            expected.push_back(build_byte(id, atc_msg_pkg::HOLD, 1'b0));
            if (action) landing_q.push_back(id);
            else takeoff_q.push_back(id);
          end
        end
      end
      3'd1: begin
        if (active[action] && owner[action] == id) active[action] = 1'b0;
        taken_map[id] = 1'b0;
      end
      3'd3: begin
        lowest = -1;
        for (i = 0; i < `ATC_NUM_IDS; i++) begin
          if (!taken_map[i] && lowest < 0) lowest = i;
        end
        if (lowest < 0) begin
          expected.push_back(build_byte('0, atc_msg_pkg::ID_PLEASE, 1'b1));
        end else begin
          expected.push_back(build_byte(`ATC_ID_WIDTH'(lowest), atc_msg_pkg::ID_PLEASE, 1'b0));
          taken_map[lowest] = 1'b1;
        end
      end
      default: expected.push_back(build_byte(id, atc_msg_pkg::SAY_AGAIN, 1'b0));
    endcase
    // Clear queue heads while a runway is free
    while (active != 2'b11 && (takeoff_q.size() > 0 || landing_q.size() > 0)) begin
      // The toggle decides only when both queues are waiting
      if (takeoff_q.size() > 0 && landing_q.size() > 0) begin
        from_takeoff = takeoff_turn;
      end else begin
        from_takeoff = (takeoff_q.size() > 0);
      end
      if (from_takeoff) begin
        plane = takeoff_q.pop_front();
      end else begin
        plane = landing_q.pop_front();
      end
      // Lower free runway first
      if (!active[0]) begin
        rw = 1'b0;
      end else begin
        rw = 1'b1;
      end
      active[rw] = 1'b1;
      owner[rw] = plane;
      takeoff_turn = !takeoff_turn;
      expected.push_back(build_byte(plane, atc_msg_pkg::CLEAR, rw));
    end
  endtask

  task automatic collect_replies(output logic ok);
    int cycles;
    atc_msg_pkg::msg_byte_t got;
    atc_msg_pkg::msg_byte_t want;
    cycles = 0;
    while (received.size() < expected.size() && cycles < REPLY_TIMEOUT) begin
      @(posedge clock);
      cycles++;
    end
    ok = (received.size() >= expected.size());
    assert (ok) else begin
      timeouts++;
      $display("Timed out waiting for %0d reply bytes, only %0d arrived",
               expected.size(), received.size());
    end
    while (expected.size() > 0 && received.size() > 0) begin
      got = received.pop_front();
      want = expected.pop_front();
      assert (got === want) else begin
        value_errors++;
        $display("Fail tx_data: got %h, expected %h", got, want);
      end
    end
  endtask

  task automatic wait_quiet();
    int cycles;
    for (cycles = 0; cycles < QUIET_CYCLES; cycles++) @(posedge clock);
  endtask

  initial begin
    logic ok;
    atc_msg_pkg::msg_byte_t message;
    int index;
    clock = 1'b0;
    reset = 1'b1;
    rx_data = '0;
    rx_valid = 1'b0;
    tx_ready = 1'b0;
    taken_map = '0;
    active = 2'b00;
    takeoff_turn = 1'b1;
    value_errors = 0;
    other_errors = 0;
    timeouts = 0;
    void'($urandom(SEED));
    fork
      drive_ready();
    join_none
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    assert (tx_send === 1'b0) else begin
      value_errors++;
      $display("Fail tx_send: got %h, expected %h", tx_send, 1'b0);
    end
    assert (runway_active === 2'b00) else begin
      value_errors++;
      $display("Fail runway_active: got %h, expected %h", runway_active, 2'b00);
    end

    ok = 1'b1;
    for (index = 0; index < NUM_MESSAGES && ok; index++) begin
      message = choose_message(index);
      apply_message(message);
      rx_data = message;
      rx_valid = 1'b1;
      @(negedge clock);
      rx_valid = 1'b0;
      collect_replies(ok);
      wait_quiet();
      assert (received.size() == 0) else begin
        other_errors++;
        $display("%0d reply bytes arrived that were not expected", received.size());
        received.delete();
      end
      @(negedge clock);
      assert (runway_active === active) else begin
        value_errors++;
        $display("Fail runway_active: got %h, expected %h", runway_active, active);
      end
    end

    $display("Sent %0d messages: %0d value errors, %0d other errors, %0d timeouts",
             index, value_errors, other_errors, timeouts);
    if (value_errors + other_errors + timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/atc_tower.sv */
//////////////////////////////////////////////////
// Tower controller top level
// Bytes in on rx_valid strobes, out on tx_send
// A byte arriving at a full request queue is lost
//////////////////////////////////////////////////

`default_nettype none

`include "atc_config.svh"

module atc_tower (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire atc_msg_pkg::msg_byte_t rx_data,
  input  wire logic                   rx_valid,
  input  wire logic                   tx_ready,
  output atc_msg_pkg::msg_byte_t      tx_data,
  output logic                        tx_send,
  output logic                  [1:0] runway_active
);

  // Request side
  atc_msg_pkg::msg_byte_t request;
  atc_msg_pkg::plane_id_t request_id;
  logic request_empty;
  logic request_read;

  // Aircraft queues
  logic takeoff_write;
  logic takeoff_read;
  logic takeoff_full;
  logic takeoff_empty;
  atc_msg_pkg::plane_id_t takeoff_head;
  logic landing_write;
  logic landing_read;
  logic landing_full;
  logic landing_empty;
  atc_msg_pkg::plane_id_t landing_head;

  // Reply side
  atc_msg_pkg::msg_byte_t reply;
  logic reply_write;
  logic reply_read;
  logic reply_full;
  logic reply_empty;

  // ID pool and runways
  atc_msg_pkg::plane_id_t free_id;
  atc_ctrl_pkg::id_map_t taken;
  logic pool_full;
  logic take_id;
  logic release_id;
  atc_ctrl_pkg::runway_t runway;
  atc_msg_pkg::plane_id_t lock_id;
  logic lock;
  logic unlock;

  assign request_id = atc_msg_pkg::msg_id(request);

  //////////////////////////////////////////////////
  // Queues
  //////////////////////////////////////////////////

  atc_fifo #(.WIDTH(8), .DEPTH(`ATC_REQUEST_DEPTH)) i_request_fifo (
    .clock(clock), .reset(reset), .data_in(rx_data), .write(rx_valid),
    .read(request_read), .data_out(request), .full(), .empty(request_empty)
  );

  atc_fifo #(.WIDTH(`ATC_ID_WIDTH), .DEPTH(`ATC_TAKEOFF_DEPTH)) i_takeoff_fifo (
    .clock(clock), .reset(reset), .data_in(request_id), .write(takeoff_write),
    .read(takeoff_read), .data_out(takeoff_head), .full(takeoff_full),
    .empty(takeoff_empty)
  );

  atc_fifo #(.WIDTH(`ATC_ID_WIDTH), .DEPTH(`ATC_LANDING_DEPTH)) i_landing_fifo (
    .clock(clock), .reset(reset), .data_in(request_id), .write(landing_write),
    .read(landing_read), .data_out(landing_head), .full(landing_full),
    .empty(landing_empty)
  );

  atc_fifo #(.WIDTH(8), .DEPTH(`ATC_REPLY_DEPTH)) i_reply_fifo (
    .clock(clock), .reset(reset), .data_in(reply), .write(reply_write),
    .read(reply_read), .data_out(tx_data), .full(reply_full), .empty(reply_empty)
  );

  //////////////////////////////////////////////////
  // Bookkeeping and control
  //////////////////////////////////////////////////

  atc_id_pool i_id_pool (
    .clock(clock), .reset(reset), .release_id_value(request_id),
    .release_strobe(release_id), .take(take_id), .free_id(free_id),
    .taken(taken), .pool_full(pool_full)
  );

  atc_runway_lock i_runway_lock (
    .clock(clock), .reset(reset), .runway(runway), .lock_id(lock_id), .lock(lock),
    .unlock_id(request_id), .unlock(unlock), .runway_active(runway_active)
  );

  atc_request_ctrl i_request_ctrl (
    .clock(clock), .reset(reset), .request_empty(request_empty), .request(request),
    .takeoff_full(takeoff_full), .takeoff_empty(takeoff_empty),
    .takeoff_head(takeoff_head), .landing_full(landing_full),
    .landing_empty(landing_empty), .landing_head(landing_head),
    .reply_full(reply_full), .taken(taken), .pool_full(pool_full), .free_id(free_id),
    .runway_active(runway_active), .request_read(request_read),
    .takeoff_write(takeoff_write), .takeoff_read(takeoff_read),
    .landing_write(landing_write), .landing_read(landing_read),
    .reply_write(reply_write), .reply(reply), .runway(runway), .lock(lock),
    .lock_id(lock_id), .unlock(unlock), .take_id(take_id), .release_id(release_id)
  );

  atc_reply_sender i_reply_sender (
    .clock(clock), .reset(reset), .reply_empty(reply_empty), .tx_ready(tx_ready),
    .reply_read(reply_read), .tx_send(tx_send)
  );

endmodule

`default_nettype wire

/* rtl/atc_reply_sender.sv */
//////////////////////////////////////////////////
// Moves reply bytes to the transmitter
// tx_data is the reply queue output, valid with
// the tx_send pulse
//////////////////////////////////////////////////

`default_nettype none

module atc_reply_sender (
  input  wire logic clock,
  input  wire logic reset,
  input  wire logic reply_empty,
  input  wire logic tx_ready,
  output logic      reply_read,
  output logic      tx_send
);

  typedef enum logic {
    WAIT,
    SEND
  } state_t;

  state_t state;

  // Start a byte only while the transmitter is ready
  assign reply_read = (state == WAIT) && !reply_empty && tx_ready;
  assign tx_send = (state == SEND);

  always_ff @(posedge clock) begin
    if (reset) state <= WAIT;
    else if (reply_read) state <= SEND;
    else state <= WAIT;
  end

endmodule

`default_nettype wire

/* rtl/atc_request_ctrl.sv */
//////////////////////////////////////////////////
// Message handling FSM with the reply register
// One message at a time, then clearances until
// both queues are empty or no runway is free
//////////////////////////////////////////////////

`default_nettype none

module atc_request_ctrl (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic                   request_empty,
  input  wire atc_msg_pkg::msg_byte_t request,
  input  wire logic                   takeoff_full,
  input  wire logic                   takeoff_empty,
  input  wire atc_msg_pkg::plane_id_t takeoff_head,
  input  wire logic                   landing_full,
  input  wire logic                   landing_empty,
  input  wire atc_msg_pkg::plane_id_t landing_head,
  input  wire logic                   reply_full,
  input  wire atc_ctrl_pkg::id_map_t  taken,
  input  wire logic                   pool_full,
  input  wire atc_msg_pkg::plane_id_t free_id,
  input  wire logic             [1:0] runway_active,
  output logic                        request_read,
  output logic                        takeoff_write,
  output logic                        takeoff_read,
  output logic                        landing_write,
  output logic                        landing_read,
  output logic                        reply_write,
  output atc_msg_pkg::msg_byte_t      reply,
  output atc_ctrl_pkg::runway_t       runway,
  output logic                        lock,
  output atc_msg_pkg::plane_id_t      lock_id,
  output logic                        unlock,
  output logic                        take_id,
  output logic                        release_id
);

  typedef enum logic [2:0] {
    QUIET,
    INTERPRET,
    REPLY,
    CHECK_QUEUES,
    CLEAR_TAKEOFF,
    CLEAR_LANDING,
    QUEUE_CLEAR
  } state_t;

  state_t state;
  state_t next_state;

  atc_msg_pkg::plane_id_t req_id;
  atc_msg_pkg::msg_type_t req_type;
  logic req_action;

  atc_ctrl_pkg::clear_kind_t pick;
  atc_ctrl_pkg::runway_t free_runway;
  logic takeoff_turn;
  logic reply_load;
  atc_msg_pkg::msg_byte_t reply_next;

  assign req_id = atc_msg_pkg::msg_id(request);
  assign req_type = atc_msg_pkg::msg_type(request);
  assign req_action = atc_msg_pkg::msg_action(request);

  // Lower free runway: 1 only when runway 0 is taken
  assign free_runway = runway_active[0];

  //////////////////////////////////////////////////
  // Queue selection
  //////////////////////////////////////////////////

  always_comb begin
    pick = atc_ctrl_pkg::NONE;
    if (runway_active != 2'b11) begin
      if (!takeoff_empty && (landing_empty || takeoff_turn)) pick = atc_ctrl_pkg::TAKEOFF;
      else if (!landing_empty) pick = atc_ctrl_pkg::LANDING;
    end
  end

  //////////////////////////////////////////////////
  // Next state and strobes
  //////////////////////////////////////////////////

  always_comb begin
    next_state = state;
    request_read = 1'b0;
    takeoff_write = 1'b0;
    takeoff_read = 1'b0;
    landing_write = 1'b0;
    landing_read = 1'b0;
    reply_write = 1'b0;
    runway = free_runway;
    lock = 1'b0;
    lock_id = (state == CLEAR_LANDING) ? landing_head : takeoff_head;
    unlock = 1'b0;
    take_id = 1'b0;
    release_id = 1'b0;
    reply_load = 1'b0;
    reply_next = atc_msg_pkg::make_msg(req_id, atc_msg_pkg::SAY_AGAIN, 1'b0);

    unique case (state)
      QUIET: begin
        if (!request_empty) begin
          request_read = 1'b1;
          next_state = INTERPRET;
        end
      end

      INTERPRET: begin
        next_state = REPLY;
        reply_load = 1'b1;
        unique case (req_type)
          atc_msg_pkg::REQUEST: begin
            if (!taken[req_id]) begin
              // Unknown plane, nothing to answer
              reply_load = 1'b0;
              next_state = CHECK_QUEUES;
            end else if (req_action ? landing_full : takeoff_full) begin
              reply_next = atc_msg_pkg::make_msg(req_id, atc_msg_pkg::DIVERT, 1'b0);
              release_id = 1'b1;
            end else begin
              reply_next = atc_msg_pkg::make_msg(req_id, atc_msg_pkg::HOLD, 1'b0);
              takeoff_write = !req_action;
              landing_write = req_action;
            end
          end
          atc_msg_pkg::DECLARE: begin
            reply_load = 1'b0;
            runway = req_action;
            unlock = 1'b1;
            release_id = 1'b1;
            next_state = CHECK_QUEUES;
          end
          atc_msg_pkg::ID_PLEASE: begin
            if (pool_full) begin
              reply_next = atc_msg_pkg::make_msg('0, atc_msg_pkg::ID_PLEASE, 1'b1);
            end else begin
              reply_next = atc_msg_pkg::make_msg(free_id, atc_msg_pkg::ID_PLEASE, 1'b0);
              take_id = 1'b1;
            end
          end
          // Retired code and reply codes keep the SAY_AGAIN default
          default: ;
        endcase
      end

      REPLY: begin
        if (!reply_full) begin
          reply_write = 1'b1;
          next_state = CHECK_QUEUES;
        end
      end

      CHECK_QUEUES: begin
        unique case (pick)
          atc_ctrl_pkg::TAKEOFF: begin
            takeoff_read = 1'b1;
            next_state = CLEAR_TAKEOFF;
          end
          atc_ctrl_pkg::LANDING: begin
            landing_read = 1'b1;
            next_state = CLEAR_LANDING;
          end
          default: next_state = QUIET;
        endcase
      end

      CLEAR_TAKEOFF, CLEAR_LANDING: begin
        // Queue head is on the registered output now
        lock = 1'b1;
        reply_load = 1'b1;
        reply_next = atc_msg_pkg::make_msg(lock_id, atc_msg_pkg::CLEAR, free_runway);
        next_state = QUEUE_CLEAR;
      end

      QUEUE_CLEAR: begin
        if (!reply_full) begin
          reply_write = 1'b1;
          next_state = CHECK_QUEUES;
        end
      end

      default: next_state = QUIET;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= QUIET;
      takeoff_turn <= 1'b1;
    end else begin
      state <= next_state;
      // Alternate queues on each clearance
      if (lock) takeoff_turn <= !takeoff_turn;
    end
  end

  always_ff @(posedge clock) begin
    if (reply_load) reply <= reply_next;
  end

endmodule

`default_nettype wire

/* rtl/atc_runway_lock.sv */
//////////////////////////////////////////////////
// Owner and active flag of the two runways
// Lock and unlock together are both ignored
//////////////////////////////////////////////////

`default_nettype none

module atc_runway_lock (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire atc_ctrl_pkg::runway_t  runway,
  input  wire atc_msg_pkg::plane_id_t lock_id,
  input  wire logic                   lock,
  input  wire atc_msg_pkg::plane_id_t unlock_id,
  input  wire logic                   unlock,
  output logic                  [1:0] runway_active
);

  atc_msg_pkg::plane_id_t owner [2];
  logic lock_only;
  logic unlock_only;

  assign lock_only = lock && !unlock;
  assign unlock_only = unlock && !lock;

  always_ff @(posedge clock) begin
    if (reset) begin
      runway_active <= 2'b00;
    end else if (lock_only) begin
      runway_active[runway] <= 1'b1;
    end else if (unlock_only && owner[runway] == unlock_id) begin
      // Only the plane holding the runway may free it
      runway_active[runway] <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (lock_only) owner[runway] <= lock_id;
  end

endmodule

`default_nettype wire

/* rtl/atc_id_pool.sv */
//////////////////////////////////////////////////
// Plane ID allocator
// free_id is the lowest free ID, and 0 when full
// Release wins over take in the same cycle
//////////////////////////////////////////////////

`default_nettype none

`include "atc_config.svh"

module atc_id_pool (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire atc_msg_pkg::plane_id_t release_id_value,
  input  wire logic                  release_strobe,
  input  wire logic                  take,
  output atc_msg_pkg::plane_id_t     free_id,
  output atc_ctrl_pkg::id_map_t      taken,
  output logic                       pool_full
);

  assign pool_full = &taken;

  // Priority search, scanning down so the lowest free bit wins
  always_comb begin
    free_id = '0;
    for (int i = `ATC_NUM_IDS - 1; i >= 0; i--) begin
      if (!taken[i]) free_id = atc_msg_pkg::plane_id_t'(i);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      taken <= '0;
    end else if (release_strobe) begin
      taken[release_id_value] <= 1'b0;
    end else if (take && !pool_full) begin
      taken[free_id] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/atc_fifo.sv */
//////////////////////////////////////////////////
// Circular queue with a registered read port
// DEPTH must be a power of two
// data_out holds its value until the next read
//////////////////////////////////////////////////

`default_nettype none

module atc_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  wire logic             clock,
  input  wire logic             reset,
  input  wire logic [WIDTH-1:0] data_in,
  input  wire logic             write,
  input  wire logic             read,
  output logic      [WIDTH-1:0] data_out,
  output logic                  full,
  output logic                  empty
);

  localparam int PTR_WIDTH = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_WIDTH-1:0] write_ptr;
  logic [PTR_WIDTH-1:0] read_ptr;
  logic [PTR_WIDTH:0] count;
  logic do_write;
  logic do_read;

  assign empty = (count == '0);
  assign full = (count == (PTR_WIDTH + 1)'(DEPTH));

  // Reads from empty and writes to full are dropped
  assign do_read = read && !empty;
  assign do_write = write && !full;

  always_ff @(posedge clock) begin
    if (reset) begin
      write_ptr <= '0;
      read_ptr <= '0;
      count <= '0;
    end else begin
      if (do_write) write_ptr <= write_ptr + 1'b1;
      if (do_read) read_ptr <= read_ptr + 1'b1;
      if (do_write && !do_read) count <= count + 1'b1;
      else if (do_read && !do_write) count <= count - 1'b1;
    end
  end

  // Storage and output register
  always_ff @(posedge clock) begin
    if (do_write) mem[write_ptr] <= data_in;
    if (do_read) data_out <= mem[read_ptr];
  end

endmodule

`default_nettype wire

/* rtl/atc_ctrl_pkg.sv */
//////////////////////////////////////////////////
// Controller-side types
// Two runways, so a runway number is one bit
//////////////////////////////////////////////////

`default_nettype none

`include "atc_config.svh"

package atc_ctrl_pkg;

  // Runway number, also sent as the action bit of CLEAR
  typedef logic runway_t;

  // One bit per plane ID, set while the ID is handed out
  typedef logic [`ATC_NUM_IDS-1:0] id_map_t;

  // Which queue a clearance is taken from
  typedef enum logic [1:0] {
    NONE    = 2'd0,
    TAKEOFF = 2'd1,
    LANDING = 2'd2
  } clear_kind_t;

endpackage

`default_nettype wire

/* rtl/atc_msg_pkg.sv */
//////////////////////////////////////////////////
// Message byte layout and type codes
// Byte is {plane ID, type, action}, MSB first
//////////////////////////////////////////////////

`default_nettype none

`include "atc_config.svh"

package atc_msg_pkg;

  typedef logic [`ATC_ID_WIDTH-1:0] plane_id_t;
  typedef logic [7:0] msg_byte_t;

  // Codes 0 to 3 arrive from aircraft, 4 to 7 are replies
  typedef enum logic [2:0] {
    REQUEST   = 3'd0,
    DECLARE   = 3'd1,
    RETIRED   = 3'd2,
    ID_PLEASE = 3'd3,
    CLEAR     = 3'd4,
    HOLD      = 3'd5,
    SAY_AGAIN = 3'd6,
    DIVERT    = 3'd7
  } msg_type_t;

  function automatic plane_id_t msg_id(msg_byte_t m);
    return m[7:4];
  endfunction

  function automatic msg_type_t msg_type(msg_byte_t m);
    return msg_type_t'(m[3:1]);
  endfunction

  function automatic logic msg_action(msg_byte_t m);
    return m[0];
  endfunction

  function automatic msg_byte_t make_msg(plane_id_t id, msg_type_t kind, logic action);
    return {id, kind, action};
  endfunction

endpackage

`default_nettype wire

/* rtl/atc_config.svh */
//////////////////////////////////////////////////
// Sizes of the tower controller
// The message format is fixed at 8 bits, so the ID
// width cannot change without a new byte layout.
// Queue depths must be powers of two.
//////////////////////////////////////////////////

`ifndef ATC_CONFIG_SVH
`define ATC_CONFIG_SVH

`define ATC_ID_WIDTH 4
`define ATC_NUM_IDS 16

// Queue depths
`define ATC_REQUEST_DEPTH 4
`define ATC_REPLY_DEPTH 4
`define ATC_TAKEOFF_DEPTH 16
`define ATC_LANDING_DEPTH 8

`endif
